//--- project.f
+incdir+tb
verilog/core_iq_pkg.sv
verilog/iq_entry_array.sv
verilog/iq_issue_select.sv
verilog/alu_reg_mdu_iq.sv
verilog/alu_reg_mdu_iq_wrapper.sv
tb/iq_tb.sv

//--- tb/iq_tb_model.svh
// outstanding op and the cycle it was driven at the wrapper input
typedef struct packed {
	core_iq_pkg::iq_enq_t enq;
	logic [31:0] cyc;
} pending_op_t;

// one bit per physical register, set by writeback
logic [63:0] pr_ready;
pending_op_t pending[$];
int unsigned mismatches;
int unsigned timeouts;

task automatic report_mismatch(input string name, input logic [63:0] got,
	input logic [63:0] exp);
	$display("[FAIL] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
	mismatches++;
endtask

task automatic check_reset_outputs();
	assert (last_iq_enq_ready == 1'b0)
		else report_mismatch("last_iq_enq_ready", 64'(last_iq_enq_ready), 64'h0);
	assert (last_alu_reg_issue_valid == 1'b0)
		else report_mismatch("last_alu_reg_issue_valid", 64'(last_alu_reg_issue_valid), 64'h0);
	assert (last_mdu_issue_valid == 1'b0)
		else report_mismatch("last_mdu_issue_valid", 64'(last_mdu_issue_valid), 64'h0);
	assert (last_issue == '0)
		else report_mismatch("last_issue", 64'(last_issue), 64'h0);
	assert (last_PRF_req == '0)
		else report_mismatch("last_PRF_req", 64'(last_PRF_req), 64'h0);
endtask

// ready seen now counts ops held in the core or entering it two drives back
task automatic compare_enq_ready(input int unsigned now);
	int unsigned held;
	logic exp_ready;
	held = 0;
	for (int i = 0; i < pending.size(); i++) begin
		if (pending[i].cyc + 2 <= now) begin
			held++;
		end
	end
	// two free slots still wanted for the ops in flight
	exp_ready = (held + 2 <= IQ_DEPTH);
	assert (last_iq_enq_ready == exp_ready)
		else report_mismatch("last_iq_enq_ready", 64'(last_iq_enq_ready), 64'(exp_ready));
endtask

// outputs seen now were decided with the bus and readies driven two cycles back
task automatic check_issue(input int unsigned now, input logic [63:0] bus,
	input logic alu_rdy, input logic mdu_rdy);
	int pick;
	logic wa;
	logic wb;
	core_iq_pkg::iq_enq_t e;
	core_iq_pkg::iq_issue_t exp_issue;
	core_iq_pkg::prf_req_t exp_req;
	logic exp_alu;
	logic exp_mdu;
	pick = -1;
	exp_issue = '0;
	exp_req = '0;
	exp_alu = 1'b0;
	exp_mdu = 1'b0;
	for (int i = 0; i < pending.size(); i++) begin
		e = pending[i].enq;
		wa = bus[e.A_PR] & ~e.A_ready & ~e.A_is_zero;
		wb = bus[e.B_PR] & ~e.B_ready & ~e.B_is_zero;
		// oldest op that is inside the queue, has its operands and a free pipe
		if (pick < 0 && pending[i].cyc + 3 <= now
			&& (e.A_ready | wa | e.A_is_zero) && (e.B_ready | wb | e.B_is_zero)
			&& ((e.is_alu_reg & alu_rdy) | (e.is_mdu & mdu_rdy))) begin
			pick = i;
			exp_alu = e.is_alu_reg;
			exp_mdu = e.is_mdu;
			exp_issue = {e.op, wa, e.A_is_zero, e.A_PR, wb, e.B_is_zero, e.B_PR,
				e.dest_PR, e.ROB_index};
			// register file read for every source neither forwarded nor zero
			exp_req = {~wa & ~e.A_is_zero, e.A_PR, ~wb & ~e.B_is_zero, e.B_PR};
		end
	end
	assert (last_alu_reg_issue_valid == exp_alu)
		else report_mismatch("last_alu_reg_issue_valid", 64'(last_alu_reg_issue_valid),
			64'(exp_alu));
	assert (last_mdu_issue_valid == exp_mdu)
		else report_mismatch("last_mdu_issue_valid", 64'(last_mdu_issue_valid), 64'(exp_mdu));
	assert (last_issue == exp_issue)
		else report_mismatch("last_issue", 64'(last_issue), 64'(exp_issue));
	assert (last_PRF_req == exp_req)
		else report_mismatch("last_PRF_req", 64'(last_PRF_req), 64'(exp_req));
	if (pick >= 0) begin
		pending.delete(pick);
	end
endtask

// a broadcast marks a source ready once its op has reached the core
task automatic apply_broadcast(input int unsigned now, input logic [63:0] bus);
	pending_op_t p;
	for (int i = 0; i < pending.size(); i++) begin
		p = pending[i];
		if (p.cyc + 2 <= now) begin
			if (bus[p.enq.A_PR] && !p.enq.A_is_zero) begin
				p.enq.A_ready = 1'b1;
			end
			if (bus[p.enq.B_PR] && !p.enq.B_is_zero) begin
				p.enq.B_ready = 1'b1;
			end
			pending[i] = p;
		end
	end
endtask

//--- tb/iq_tb.sv
`timescale 1ns/1ps

module iq_tb;

	localparam int OP_COUNT = 300;
	localparam int RUN_LIMIT = 40000;
	localparam int DRAIN_LIMIT = 400;
	localparam int IQ_DEPTH = 4;
	localparam int UPPER_W = core_iq_pkg::LOG_PR_COUNT - core_iq_pkg::LOG_PRF_BANK_COUNT;

	logic CLK;
	logic nRST;
	logic next_iq_enq_valid;
	core_iq_pkg::iq_enq_t next_iq_enq;
	logic [core_iq_pkg::PRF_BANK_COUNT-1:0] next_WB_bus_valid_by_bank;
	logic [core_iq_pkg::PRF_BANK_COUNT-1:0][UPPER_W-1:0] next_WB_bus_upper_PR_by_bank;
	logic next_alu_reg_issue_ready;
	logic next_mdu_issue_ready;
	logic last_iq_enq_ready;
	logic last_alu_reg_issue_valid;
	logic last_mdu_issue_valid;
	core_iq_pkg::iq_issue_t last_issue;
	core_iq_pkg::prf_req_t last_PRF_req;

	// broadcast masks and {alu, mdu} readies of the last two drives
	logic [63:0] bus_d1;
	logic [63:0] bus_d2;
	logic [1:0] rdy_d1;
	logic [1:0] rdy_d2;
	int unsigned sent;

	`include "iq_tb_model.svh"

	alu_reg_mdu_iq_wrapper #(
		.IQ_ENTRIES(IQ_DEPTH)
	) dut_i (
		.CLK(CLK),
		.nRST(nRST),
		.next_iq_enq_valid(next_iq_enq_valid),
		.next_iq_enq(next_iq_enq),
		.last_iq_enq_ready(last_iq_enq_ready),
		.next_WB_bus_valid_by_bank(next_WB_bus_valid_by_bank),
		.next_WB_bus_upper_PR_by_bank(next_WB_bus_upper_PR_by_bank),
		.next_alu_reg_issue_ready(next_alu_reg_issue_ready),
		.next_mdu_issue_ready(next_mdu_issue_ready),
		.last_alu_reg_issue_valid(last_alu_reg_issue_valid),
		.last_mdu_issue_valid(last_mdu_issue_valid),
		.last_issue(last_issue),
		.last_PRF_req(last_PRF_req)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------

	// sources take their ready bit from the table, dest goes not ready
	function automatic core_iq_pkg::iq_enq_t build_op(input int unsigned rob);
		core_iq_pkg::iq_enq_t op;
		op = '0;
		op.is_alu_reg = 1'($urandom_range(1));
		op.is_mdu = ~op.is_alu_reg;
		op.op = 4'($urandom);
		op.A_PR = ($urandom_range(7) == 0) ? 6'd0 : 6'($urandom);
		op.B_PR = ($urandom_range(7) == 0) ? 6'd0 : 6'($urandom);
		op.A_is_zero = (op.A_PR == 6'd0);
		op.B_is_zero = (op.B_PR == 6'd0);
		op.A_ready = pr_ready[op.A_PR];
		op.B_ready = pr_ready[op.B_PR];
		op.dest_PR = 6'($urandom_range(63, 1));
		op.ROB_index = 5'(rob);
		pr_ready[op.dest_PR] = 1'b0;
		return op;
	endfunction

	task automatic drive_inputs(input int unsigned now, input logic drain);
		logic [63:0] mask;
		logic [1:0] rdy;
		logic lane_valid;
		logic [UPPER_W-1:0] upper;
		pending_op_t p;
		mask = '0;
		next_iq_enq_valid = 1'b0;
		next_iq_enq = '0;
		if (!drain && last_iq_enq_ready && sent < OP_COUNT && $urandom_range(3) != 0) begin
			p.enq = build_op(sent);
			p.cyc = now;
			pending.push_back(p);
			next_iq_enq = p.enq;
			next_iq_enq_valid = 1'b1;
			sent++;
		end
		for (int b = 0; b < core_iq_pkg::PRF_BANK_COUNT; b++) begin
			// drain sweeps every register once per 16 cycles
			lane_valid = drain ? 1'b1 : ($urandom_range(3) != 0);
			upper = drain ? UPPER_W'(now) : UPPER_W'($urandom);
			next_WB_bus_valid_by_bank[b] = lane_valid;
			next_WB_bus_upper_PR_by_bank[b] = upper;
			if (lane_valid) begin
				mask[{upper, 2'(b)}] = 1'b1;
				pr_ready[{upper, 2'(b)}] = 1'b1;
			end
		end
		rdy = drain ? 2'b11 : 2'($urandom);
		next_alu_reg_issue_ready = rdy[1];
		next_mdu_issue_ready = rdy[0];
		bus_d2 = bus_d1;
		bus_d1 = mask;
		rdy_d2 = rdy_d1;
		rdy_d1 = rdy;
	endtask

	task automatic run_cycle(input int unsigned now, input logic drain);
		compare_enq_ready(now);
		check_issue(now, bus_d2, rdy_d2[1], rdy_d2[0]);
		apply_broadcast(now, bus_d2);
		drive_inputs(now, drain);
	endtask

	// ------------------------------------------------------------
	// sequence
	// ------------------------------------------------------------

	initial begin
		int unsigned cyc;
		int unsigned wait_cnt;
		mismatches = 0;
		timeouts = 0;
		sent = 0;
		void'($urandom(92853));
		for (int r = 0; r < 64; r++) begin
			pr_ready[r] = 1'($urandom_range(1));
		end
		pr_ready[0] = 1'b1;
		nRST = 1'b0;
		next_iq_enq_valid = 1'b0;
		next_iq_enq = '0;
		next_WB_bus_valid_by_bank = '0;
		next_WB_bus_upper_PR_by_bank = '0;
		next_alu_reg_issue_ready = 1'b0;
		next_mdu_issue_ready = 1'b0;
		bus_d1 = '0;
		bus_d2 = '0;
		rdy_d1 = '0;
		rdy_d2 = '0;
		cyc = 0;
		repeat (2) begin
			@(negedge CLK);
			cyc++;
			check_reset_outputs();
		end
		nRST = 1'b1;

		wait_cnt = 0;
		while (sent < OP_COUNT && wait_cnt < RUN_LIMIT) begin
			@(negedge CLK);
			cyc++;
			wait_cnt++;
			run_cycle(cyc, 1'b0);
		end
		if (sent < OP_COUNT) begin
			$display("timeout: only %0d of %0d ops were accepted", sent, OP_COUNT);
			timeouts++;
		end

		wait_cnt = 0;
		while (pending.size() != 0 && wait_cnt < DRAIN_LIMIT) begin
			@(negedge CLK);
			cyc++;
			wait_cnt++;
			run_cycle(cyc, 1'b1);
		end
		if (pending.size() != 0) begin
			$display("timeout: %0d ops never issued during drain", pending.size());
			timeouts++;
		end
		// quiet cycles catch any issue with nothing outstanding
		repeat (4) begin
			@(negedge CLK);
			cyc++;
			run_cycle(cyc, 1'b1);
		end

		$display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- verilog/alu_reg_mdu_iq_wrapper.sv
`timescale 1ns/1ps

module alu_reg_mdu_iq_wrapper #(
	parameter int IQ_ENTRIES = core_iq_pkg::IQ_ENTRIES
) (
	input logic CLK,
	input logic nRST,

	// dispatch
	input logic next_iq_enq_valid,
	input core_iq_pkg::iq_enq_t next_iq_enq,
	output logic last_iq_enq_ready,

	// writeback bus, one lane per bank
	input logic [core_iq_pkg::PRF_BANK_COUNT-1:0] next_WB_bus_valid_by_bank,
	input logic [core_iq_pkg::PRF_BANK_COUNT-1:0]
		[core_iq_pkg::LOG_PR_COUNT-core_iq_pkg::LOG_PRF_BANK_COUNT-1:0]
		next_WB_bus_upper_PR_by_bank,

	// pipeline feedback
	input logic next_alu_reg_issue_ready,
	input logic next_mdu_issue_ready,

	// issue side
	output logic last_alu_reg_issue_valid,
	output logic last_mdu_issue_valid,
	output core_iq_pkg::iq_issue_t last_issue,
	output core_iq_pkg::prf_req_t last_PRF_req
);

	// ------------------------------------------------------------
	// core side signals
	// ------------------------------------------------------------

	logic iq_enq_valid;
	core_iq_pkg::iq_enq_t iq_enq;
	logic iq_enq_ready;

	logic [core_iq_pkg::PRF_BANK_COUNT-1:0] WB_bus_valid_by_bank;
	logic [core_iq_pkg::PRF_BANK_COUNT-1:0]
		[core_iq_pkg::LOG_PR_COUNT-core_iq_pkg::LOG_PRF_BANK_COUNT-1:0] WB_bus_upper_PR_by_bank;

	logic alu_reg_issue_ready;
	logic mdu_issue_ready;

	logic alu_reg_issue_valid;
	logic mdu_issue_valid;
	core_iq_pkg::iq_issue_t issue;
	core_iq_pkg::prf_req_t PRF_req;

	alu_reg_mdu_iq #(
		.IQ_ENTRIES(IQ_ENTRIES)
	) core_i (.*);

	// ------------------------------------------------------------
	// boundary registers
	// ------------------------------------------------------------

	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			iq_enq_valid <= 1'b0;
			iq_enq <= '0;
			WB_bus_valid_by_bank <= '0;
			WB_bus_upper_PR_by_bank <= '0;
			alu_reg_issue_ready <= 1'b0;
			mdu_issue_ready <= 1'b0;

			last_iq_enq_ready <= 1'b0;
			last_alu_reg_issue_valid <= 1'b0;
			last_mdu_issue_valid <= 1'b0;
			last_issue <= '0;
			last_PRF_req <= '0;
		end else begin
			// inputs toward the core
			iq_enq_valid <= next_iq_enq_valid;
			iq_enq <= next_iq_enq;
			WB_bus_valid_by_bank <= next_WB_bus_valid_by_bank;
			WB_bus_upper_PR_by_bank <= next_WB_bus_upper_PR_by_bank;
			alu_reg_issue_ready <= next_alu_reg_issue_ready;
			mdu_issue_ready <= next_mdu_issue_ready;

			// core outputs
			last_iq_enq_ready <= iq_enq_ready;
			last_alu_reg_issue_valid <= alu_reg_issue_valid;
			last_mdu_issue_valid <= mdu_issue_valid;
			last_issue <= issue;
			last_PRF_req <= PRF_req;
		end
	end

endmodule

//--- verilog/alu_reg_mdu_iq.sv
`timescale 1ns/1ps

module alu_reg_mdu_iq #(
	parameter int IQ_ENTRIES = core_iq_pkg::IQ_ENTRIES
) (
	input logic CLK,
	input logic nRST,

	input logic iq_enq_valid,
	input core_iq_pkg::iq_enq_t iq_enq,
	output logic iq_enq_ready,

	input logic [core_iq_pkg::PRF_BANK_COUNT-1:0] WB_bus_valid_by_bank,
	input logic [core_iq_pkg::PRF_BANK_COUNT-1:0]
		[core_iq_pkg::LOG_PR_COUNT-core_iq_pkg::LOG_PRF_BANK_COUNT-1:0] WB_bus_upper_PR_by_bank,

	input logic alu_reg_issue_ready,
	input logic mdu_issue_ready,

	output logic alu_reg_issue_valid,
	output logic mdu_issue_valid,
	output core_iq_pkg::iq_issue_t issue,
	output core_iq_pkg::prf_req_t PRF_req
);

	localparam int CNT_W = $clog2(IQ_ENTRIES + 1);
	localparam int IDX_W = $clog2(IQ_ENTRIES);

	core_iq_pkg::iq_entry_t [IQ_ENTRIES-1:0] entries;
	logic [IQ_ENTRIES-1:0] wake_A;
	logic [IQ_ENTRIES-1:0] wake_B;
	logic issue_valid;
	logic [IDX_W-1:0] issue_index;

	logic [CNT_W-1:0] free_count;
	logic [CNT_W-1:0] free_after;
	logic enq_accept;

	// ------------------------------------------------------------
	// occupancy and enqueue flow control
	// ------------------------------------------------------------

	always_comb begin
		free_count = '0;
		for (int i = 0; i < IQ_ENTRIES; i++) begin
			if (~entries[i].valid) begin
				free_count = free_count + CNT_W'(1);
			end
		end
	end

	assign enq_accept = iq_enq_valid & (free_count != '0);
	assign free_after = free_count - CNT_W'(enq_accept);

	// two slots beyond the op entering now cover the ops still in
	// the wrapper registers and the one decided on a stale ready
	assign iq_enq_ready = free_after > CNT_W'(1);

	iq_entry_array #(
		.IQ_ENTRIES(IQ_ENTRIES)
	) entry_array_i (
		.CLK(CLK),
		.nRST(nRST),
		.enq_valid(enq_accept),
		.enq(iq_enq),
		.WB_bus_valid_by_bank(WB_bus_valid_by_bank),
		.WB_bus_upper_PR_by_bank(WB_bus_upper_PR_by_bank),
		.issue_valid(issue_valid),
		.issue_index(issue_index),
		.entries(entries),
		.wake_A(wake_A),
		.wake_B(wake_B)
	);

	iq_issue_select #(
		.IQ_ENTRIES(IQ_ENTRIES)
	) issue_select_i (
		.entries(entries),
		.wake_A(wake_A),
		.wake_B(wake_B),
		.alu_reg_ready(alu_reg_issue_ready),
		.mdu_ready(mdu_issue_ready),
		.issue_valid(issue_valid),
		.issue_index(issue_index),
		.alu_reg_issue_valid(alu_reg_issue_valid),
		.mdu_issue_valid(mdu_issue_valid),
		.issue(issue),
		.PRF_req(PRF_req)
	);

endmodule

//--- verilog/iq_issue_select.sv
`timescale 1ns/1ps

module iq_issue_select #(
	parameter int IQ_ENTRIES = core_iq_pkg::IQ_ENTRIES
) (
	input core_iq_pkg::iq_entry_t [IQ_ENTRIES-1:0] entries,
	input logic [IQ_ENTRIES-1:0] wake_A,
	input logic [IQ_ENTRIES-1:0] wake_B,

	input logic alu_reg_ready,
	input logic mdu_ready,

	output logic issue_valid,
	output logic [$clog2(IQ_ENTRIES)-1:0] issue_index,

	output logic alu_reg_issue_valid,
	output logic mdu_issue_valid,
	output core_iq_pkg::iq_issue_t issue,
	output core_iq_pkg::prf_req_t PRF_req
);

	localparam int IDX_W = $clog2(IQ_ENTRIES);

	logic [IQ_ENTRIES-1:0] eligible;
	core_iq_pkg::iq_enq_t sel;
	logic sel_wake_A;
	logic sel_wake_B;

	// ------------------------------------------------------------
	// eligibility and oldest-first pick
	// ------------------------------------------------------------

	always_comb begin
		for (int i = 0; i < IQ_ENTRIES; i++) begin
			eligible[i] = entries[i].valid
				& (entries[i].enq.A_ready | wake_A[i] | entries[i].enq.A_is_zero)
				& (entries[i].enq.B_ready | wake_B[i] | entries[i].enq.B_is_zero)
				& ((entries[i].enq.is_alu_reg & alu_reg_ready)
					| (entries[i].enq.is_mdu & mdu_ready));
		end
	end

	// scan from the top so the lowest eligible index wins
	always_comb begin
		issue_valid = 1'b0;
		issue_index = '0;
		for (int i = IQ_ENTRIES - 1; i >= 0; i--) begin
			if (eligible[i]) begin
				issue_valid = 1'b1;
				issue_index = IDX_W'(i);
			end
		end
	end

	assign sel = entries[issue_index].enq;
	assign sel_wake_A = wake_A[issue_index];
	assign sel_wake_B = wake_B[issue_index];

	// ------------------------------------------------------------
	// issue fields and PRF reads
	// ------------------------------------------------------------

	always_comb begin
		alu_reg_issue_valid = 1'b0;
		mdu_issue_valid = 1'b0;
		issue = '0;
		PRF_req = '0;

		if (issue_valid) begin
			alu_reg_issue_valid = sel.is_alu_reg & alu_reg_ready;
			mdu_issue_valid = sel.is_mdu & mdu_ready;

			issue.op = sel.op;
			issue.A_forward = sel_wake_A & ~sel.A_is_zero;
			issue.A_is_zero = sel.A_is_zero;
			issue.A_PR = sel.A_PR;
			issue.B_forward = sel_wake_B & ~sel.B_is_zero;
			issue.B_is_zero = sel.B_is_zero;
			issue.B_PR = sel.B_PR;
			issue.dest_PR = sel.dest_PR;
			issue.ROB_index = sel.ROB_index;

			// value already written back, read it from the PRF
			PRF_req.A_valid = sel.A_ready & ~sel.A_is_zero;
			PRF_req.A_PR = sel.A_PR;
			PRF_req.B_valid = sel.B_ready & ~sel.B_is_zero;
			PRF_req.B_PR = sel.B_PR;
		end
	end

endmodule

//--- verilog/iq_entry_array.sv
`timescale 1ns/1ps

module iq_entry_array #(
	parameter int IQ_ENTRIES = core_iq_pkg::IQ_ENTRIES
) (
	input logic CLK,
	input logic nRST,

	input logic enq_valid,
	input core_iq_pkg::iq_enq_t enq,

	input logic [core_iq_pkg::PRF_BANK_COUNT-1:0] WB_bus_valid_by_bank,
	input logic [core_iq_pkg::PRF_BANK_COUNT-1:0]
		[core_iq_pkg::LOG_PR_COUNT-core_iq_pkg::LOG_PRF_BANK_COUNT-1:0] WB_bus_upper_PR_by_bank,

	input logic issue_valid,
	input logic [$clog2(IQ_ENTRIES)-1:0] issue_index,

	output core_iq_pkg::iq_entry_t [IQ_ENTRIES-1:0] entries,
	output logic [IQ_ENTRIES-1:0] wake_A,
	output logic [IQ_ENTRIES-1:0] wake_B
);

	// slot 0 holds the oldest op
	logic [IQ_ENTRIES-1:0] valid_q;
	core_iq_pkg::iq_enq_t [IQ_ENTRIES-1:0] op_q;

	core_iq_pkg::iq_enq_t [IQ_ENTRIES-1:0] woke_op;
	core_iq_pkg::iq_enq_t enq_woke;
	logic [IQ_ENTRIES-1:0] valid_d;
	core_iq_pkg::iq_enq_t [IQ_ENTRIES-1:0] op_d;
	logic enq_placed;

	// bank from the low bits, tag match on the upper bits
	function automatic logic pr_on_bus(
		input logic [core_iq_pkg::LOG_PR_COUNT-1:0] pr,
		input logic [core_iq_pkg::PRF_BANK_COUNT-1:0] bus_valid,
		input logic [core_iq_pkg::PRF_BANK_COUNT-1:0]
			[core_iq_pkg::LOG_PR_COUNT-core_iq_pkg::LOG_PRF_BANK_COUNT-1:0] bus_upper
	);
		logic [core_iq_pkg::LOG_PRF_BANK_COUNT-1:0] bank;
		bank = pr[core_iq_pkg::LOG_PRF_BANK_COUNT-1:0];
		return bus_valid[bank] &&
			(bus_upper[bank] == pr[core_iq_pkg::LOG_PR_COUNT-1:core_iq_pkg::LOG_PRF_BANK_COUNT]);
	endfunction

	// ------------------------------------------------------------
	// wakeup
	// ------------------------------------------------------------

	always_comb begin
		for (int i = 0; i < IQ_ENTRIES; i++) begin
			entries[i].valid = valid_q[i];
			entries[i].enq = op_q[i];

			wake_A[i] = valid_q[i] & ~op_q[i].A_ready & ~op_q[i].A_is_zero
				& pr_on_bus(op_q[i].A_PR, WB_bus_valid_by_bank, WB_bus_upper_PR_by_bank);
			wake_B[i] = valid_q[i] & ~op_q[i].B_ready & ~op_q[i].B_is_zero
				& pr_on_bus(op_q[i].B_PR, WB_bus_valid_by_bank, WB_bus_upper_PR_by_bank);

			woke_op[i] = op_q[i];
			woke_op[i].A_ready = op_q[i].A_ready | wake_A[i];
			woke_op[i].B_ready = op_q[i].B_ready | wake_B[i];
		end
	end

	// an op entering now must not miss a broadcast of its sources
	always_comb begin
		enq_woke = enq;
		if (~enq.A_is_zero &&
			pr_on_bus(enq.A_PR, WB_bus_valid_by_bank, WB_bus_upper_PR_by_bank)) begin
			enq_woke.A_ready = 1'b1;
		end
		if (~enq.B_is_zero &&
			pr_on_bus(enq.B_PR, WB_bus_valid_by_bank, WB_bus_upper_PR_by_bank)) begin
			enq_woke.B_ready = 1'b1;
		end
	end

	// ------------------------------------------------------------
	// compaction and enqueue
	// ------------------------------------------------------------

	always_comb begin
		enq_placed = 1'b0;

		for (int i = 0; i < IQ_ENTRIES - 1; i++) begin
			if (issue_valid && i >= int'(issue_index)) begin
				valid_d[i] = valid_q[i+1];
				op_d[i] = woke_op[i+1];
			end else begin
				valid_d[i] = valid_q[i];
				op_d[i] = woke_op[i];
			end
		end
		// top slot always empties on an issue
		valid_d[IQ_ENTRIES-1] = valid_q[IQ_ENTRIES-1] & ~issue_valid;
		op_d[IQ_ENTRIES-1] = woke_op[IQ_ENTRIES-1];

		// new op lands behind everything that survived the shift
		for (int i = 0; i < IQ_ENTRIES; i++) begin
			if (enq_valid && ~enq_placed && ~valid_d[i]) begin
				valid_d[i] = 1'b1;
				op_d[i] = enq_woke;
				enq_placed = 1'b1;
			end
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			valid_q <= '0;
		end else begin
			valid_q <= valid_d;
		end
	end

	always_ff @(posedge CLK) begin
		op_q <= op_d;
	end

endmodule

//--- verilog/core_iq_pkg.sv
package core_iq_pkg;

	// ------------------------------------------------------------
	// sizing
	// ------------------------------------------------------------

	parameter int LOG_PR_COUNT = 6;
	parameter int LOG_ROB_ENTRIES = 5;
	parameter int PRF_BANK_COUNT = 4;
	parameter int LOG_PRF_BANK_COUNT = 2;

	// default depth, overridden by the top level
	parameter int IQ_ENTRIES = 4;

	// ------------------------------------------------------------
	// dispatch, storage and issue records
	// ------------------------------------------------------------

	typedef struct packed {
		logic is_alu_reg;
		logic is_mdu;
		logic [3:0] op;
		logic [LOG_PR_COUNT-1:0] A_PR;
		logic A_ready;
		logic A_is_zero;
		logic [LOG_PR_COUNT-1:0] B_PR;
		logic B_ready;
		logic B_is_zero;
		logic [LOG_PR_COUNT-1:0] dest_PR;
		logic [LOG_ROB_ENTRIES-1:0] ROB_index;
	} iq_enq_t;

	// one queue slot
	typedef struct packed {
		logic valid;
		iq_enq_t enq;
	} iq_entry_t;

	typedef struct packed {
		logic [3:0] op;
		logic A_forward;
		logic A_is_zero;
		logic [LOG_PR_COUNT-1:0] A_PR;
		logic B_forward;
		logic B_is_zero;
		logic [LOG_PR_COUNT-1:0] B_PR;
		logic [LOG_PR_COUNT-1:0] dest_PR;
		logic [LOG_ROB_ENTRIES-1:0] ROB_index;
	} iq_issue_t;

	// register file read request, one port per source
	typedef struct packed {
		logic A_valid;
		logic [LOG_PR_COUNT-1:0] A_PR;
		logic B_valid;
		logic [LOG_PR_COUNT-1:0] B_PR;
	} prf_req_t;

endpackage
